/* design/fdc_bus_pkg.sv */
package fdc_bus_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [1:0] reg_addr_t;

	// ==============================
	// host register map
	// ==============================
	localparam reg_addr_t A_COMMAND = 2'd0;  // write side
	localparam reg_addr_t A_STATUS  = 2'd0;  // read side
	localparam reg_addr_t A_TRACK   = 2'd1;
	localparam reg_addr_t A_SECTOR  = 2'd2;
	localparam reg_addr_t A_DATA    = 2'd3;

	// command codes, upper nibble of the command byte
	localparam logic [3:0] CMD_RESTORE    = 4'h0;
	localparam logic [3:0] CMD_SEEK       = 4'h1;
	localparam logic [3:0] CMD_STEP       = 4'h2;
	localparam logic [3:0] CMD_STEP_U     = 4'h3;
	localparam logic [3:0] CMD_STEP_IN    = 4'h4;
	localparam logic [3:0] CMD_STEP_IN_U  = 4'h5;
	localparam logic [3:0] CMD_STEP_OUT   = 4'h6;
	localparam logic [3:0] CMD_STEP_OUT_U = 4'h7;
	localparam logic [3:0] CMD_READ       = 4'h8;
	localparam logic [3:0] CMD_READ_M     = 4'h9;
	localparam logic [3:0] CMD_WRITE      = 4'hA;
	localparam logic [3:0] CMD_WRITE_M    = 4'hB;
	localparam logic [3:0] CMD_FORCE_INT  = 4'hD;

	// status bits; type I meaning first, type II second where they differ
	localparam int ST_BUSY        = 0;
	localparam int ST_INDEX       = 1;
	localparam int ST_DRQ         = 1;
	localparam int ST_TRACK0      = 2;
	localparam int ST_LOST_DATA   = 2;
	localparam int ST_CRC_ERR     = 3;
	localparam int ST_SEEK_ERR    = 4;  // record not found in type II
	localparam int ST_HEAD_LOADED = 5;
	localparam int ST_WR_FAULT    = 5;
	localparam int ST_WPROT       = 6;
	localparam int ST_NOT_READY   = 7;

	// ==============================
	// structs
	// ==============================
	typedef struct packed {
		logic      rd;
		logic      wr;
		reg_addr_t addr;
		byte_t     wdata;
	} host_bus_t;

	typedef struct packed {
		logic  issue;  // one cycle per accepted command
		byte_t code;
	} cmd_t;

	typedef struct packed {
		logic  track_ld;
		byte_t track;
		logic  sector_inc;
		logic  data_ld;
		byte_t data;
		logic  data_clr;   // drop a pending data access
	} reg_upd_t;

	typedef struct packed {
		logic busy;
		logic drq;
		logic intrq;
		logic head_loaded;
		logic seek_err;
		logic wr_fault;
		logic lost_data;
		logic cmd_mode;    // 0 type I status, 1 type II
		logic track0;
	} fdc_flags_t;

endpackage

/* design/fdc_disk_pkg.sv */
package fdc_disk_pkg;

	typedef logic [7:0]  track_t;
	typedef logic [7:0]  sector_t;
	typedef logic [19:0] img_addr_t;   // byte address into the image
	typedef logic [10:0] sec_len_t;    // up to 1024 bytes
	typedef logic [2:0]  size_code_t;

	// ==============================
	// image memory port
	// ==============================
	// read data comes back one cycle after rd
	typedef struct packed {
		logic       rd;
		logic       wr;
		img_addr_t  addr;
		logic [7:0] wdata;
	} img_req_t;

	// where the head is, as the geometry block sees it
	typedef struct packed {
		track_t  track;
		logic    side;
		sector_t sector;
	} disk_pos_t;

endpackage

/* design/fdc_geometry.sv */
`timescale 1ns/1ps

module fdc_geometry (
	input  fdc_disk_pkg::size_code_t size_code,
	input  logic                     layout,     // 0 track-side-sector, 1 side-track-sector
	input  fdc_disk_pkg::img_addr_t  disk_size,
	input  fdc_disk_pkg::disk_pos_t  pos,
	input  fdc_disk_pkg::sec_len_t   byte_idx,
	output fdc_disk_pkg::sector_t    spt,
	output fdc_disk_pkg::sec_len_t   sec_len,
	output fdc_disk_pkg::img_addr_t  img_addr
);
	import fdc_disk_pkg::*;

	logic [1:0] len_code;   // sector is 128 << len_code
	img_addr_t  trk_idx;
	img_addr_t  side_off;
	img_addr_t  sec_base;

	// ==============================
	// fixed track table
	// ==============================
	always_comb begin
		case (size_code)
			3'd0:    spt = 8'd26;
			3'd1:    spt = 8'd16;
			3'd2:    spt = 8'd9;
			3'd3:    spt = 8'd5;
			3'd4:    spt = 8'd10;
			default: spt = 8'd26;
		endcase
		case (size_code)
			3'd0:    len_code = 2'd0;
			3'd1:    len_code = 2'd1;
			3'd2:    len_code = 2'd2;
			3'd3:    len_code = 2'd3;
			3'd4:    len_code = 2'd2;
			default: len_code = 2'd0;
		endcase
		sec_len = sec_len_t'(128) << len_code;
	end

	// ==============================
	// image address
	// ==============================
	always_comb begin
		if (layout) begin
			// second side lives in the upper half of the image
			trk_idx  = img_addr_t'(pos.track);
			side_off = pos.side ? (disk_size >> 1) : '0;
		end else begin
			trk_idx  = img_addr_t'({pos.track, pos.side}); // track*2 + side
			side_off = '0;
		end
		sec_base = trk_idx * img_addr_t'(spt) + img_addr_t'(pos.sector) - img_addr_t'(1);
		// sector sizes are powers of two
		img_addr = side_off + (sec_base << (7 + len_code)) + img_addr_t'(byte_idx);
	end

endmodule

/* design/fdc_regs.sv */
`timescale 1ns/1ps

module fdc_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  fdc_bus_pkg::host_bus_t  host,
	output fdc_bus_pkg::byte_t      dout,
	input  fdc_bus_pkg::fdc_flags_t flags,
	input  fdc_bus_pkg::reg_upd_t   upd,
	input  logic                    ready,
	input  logic                    wp,
	output fdc_bus_pkg::cmd_t       cmd,
	output logic                    data_ack,
	output logic                    intrq_ack,
	output fdc_disk_pkg::track_t    track_reg,
	output fdc_disk_pkg::sector_t   sector_reg,
	output fdc_bus_pkg::byte_t      data_reg
);
	import fdc_bus_pkg::*;

	logic      rd_q;
	logic      wr_q;
	logic      rd_rise;
	logic      rd_fall;
	logic      wr_rise;
	logic      wr_fall;
	reg_addr_t cur_addr;   // register of the access in progress
	logic      cmd_issue;
	byte_t     cmd_code;
	logic      cmd_ok;
	byte_t     status;

	assign rd_rise = host.rd & ~rd_q;
	assign rd_fall = rd_q & ~host.rd;
	assign wr_rise = host.wr & ~wr_q;
	assign wr_fall = wr_q & ~host.wr;

	// force interrupt gets through even while busy
	assign cmd_ok = ~flags.busy | (host.wdata[7:4] == CMD_FORCE_INT);

	always_comb begin
		cmd.issue = cmd_issue;
		cmd.code  = cmd_code;
	end

	// ==============================
	// strobes and registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q       <= 1'b0;
			wr_q       <= 1'b0;
			cur_addr   <= A_STATUS;
			cmd_issue  <= 1'b0;
			data_ack   <= 1'b0;
			intrq_ack  <= 1'b0;
			track_reg  <= '0;
			sector_reg <= 8'd1;
			data_reg   <= '0;
		end else begin
			rd_q      <= host.rd;
			wr_q      <= host.wr;
			cmd_issue <= 1'b0;
			intrq_ack <= rd_fall && (cur_addr == A_STATUS);

			if (rd_rise || wr_rise)
				cur_addr <= host.addr;

			if (upd.data_clr)
				data_ack <= 1'b0;
			if ((rd_fall || wr_fall) && (cur_addr == A_DATA))
				data_ack <= 1'b1;     // byte taken or given

			if (wr_rise) begin
				case (host.addr)
					A_COMMAND: cmd_issue <= cmd_ok;
					A_TRACK:   if (!flags.busy) track_reg <= host.wdata;
					A_SECTOR:  if (!flags.busy) sector_reg <= host.wdata;
					A_DATA:    data_reg <= host.wdata;
				endcase
			end

			// sequencer updates win over the host
			if (upd.track_ld)
				track_reg <= upd.track;
			if (upd.sector_inc)
				sector_reg <= sector_reg + 1'b1;
			if (upd.data_ld)
				data_reg <= upd.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise && (host.addr == A_COMMAND))
			cmd_code <= host.wdata;
	end

	// ==============================
	// status and read mux
	// ==============================
	always_comb begin
		status               = '0;
		status[ST_BUSY]      = flags.busy;
		status[ST_CRC_ERR]   = 1'b0;               // no crc in an image
		status[ST_SEEK_ERR]  = flags.seek_err | ~ready;
		status[ST_WPROT]     = wp;
		status[ST_NOT_READY] = ~ready;
		if (flags.cmd_mode) begin
			status[ST_DRQ]       = flags.drq;
			status[ST_LOST_DATA] = flags.lost_data;
			status[ST_WR_FAULT]  = flags.wr_fault;
		end else begin
			status[ST_INDEX]       = 1'b0;   // no index pulse
			status[ST_TRACK0]      = flags.track0;
			status[ST_HEAD_LOADED] = flags.head_loaded;
		end
	end

	always_comb begin
		case (host.addr)
			A_STATUS: dout = status;
			A_TRACK:  dout = track_reg;
			A_SECTOR: dout = sector_reg;
			default:  dout = data_reg;
		endcase
	end

endmodule

/* design/fdc_seq.sv */
`timescale 1ns/1ps

module fdc_seq #(
	parameter int SETTLE_CYCLES     = 4000,
	parameter int DRQ_DELAY         = 15,
	parameter int LOST_DATA_TIMEOUT = 4096
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  fdc_bus_pkg::cmd_t       cmd,
	input  logic                    data_ack,
	input  logic                    intrq_ack,
	input  fdc_disk_pkg::track_t    track_reg,
	input  fdc_disk_pkg::sector_t   sector_reg,
	input  fdc_bus_pkg::byte_t      data_reg,
	input  logic                    ready,
	input  logic                    wp,
	input  logic                    side,
	input  fdc_disk_pkg::sector_t   spt,
	input  fdc_disk_pkg::sec_len_t  sec_len,
	input  fdc_disk_pkg::img_addr_t img_addr,
	output fdc_disk_pkg::disk_pos_t pos,
	output fdc_disk_pkg::sec_len_t  byte_idx,
	output fdc_bus_pkg::reg_upd_t   upd,
	output fdc_bus_pkg::fdc_flags_t flags,
	output fdc_disk_pkg::img_req_t  img,
	input  fdc_bus_pkg::byte_t      img_rdata
);
	import fdc_bus_pkg::*;
	import fdc_disk_pkg::*;

	localparam int CNT_W = $clog2(SETTLE_CYCLES + DRQ_DELAY + LOST_DATA_TIMEOUT + 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_SETTLE,
		S_SEARCH,
		S_RD_ISSUE,
		S_RD_CAPTURE,
		S_RD_WAIT,
		S_WR_WAIT,
		S_WR_COMMIT,
		S_END
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;          // settle, drq delay and lost data timer
	track_t           head_track;   // real head position
	logic             step_dir;     // 1 = towards track 0
	logic             multi;
	logic             is_write;
	logic             busy;
	logic             drq;
	logic             intrq;
	logic             head_loaded;
	logic             seek_err;
	logic             wr_fault;
	logic             lost_data;
	logic             cmd_mode;

	logic [3:0] op;
	logic       cmd_go;
	logic       step_out;
	track_t     step_track;
	track_t     seek_track;
	logic       cnt_zero;
	logic       in_wait;
	logic       xfer_done;
	logic       byte_step;
	logic       byte_last;

	assign op       = cmd.code[7:4];
	assign cmd_go   = cmd.issue & ((state == S_IDLE) | (state == S_END) | (op == CMD_FORCE_INT));
	assign cnt_zero = (cnt == '0);
	assign in_wait  = (state == S_RD_WAIT) | (state == S_WR_WAIT);
	assign xfer_done = in_wait & drq & (data_ack | cnt_zero);   // taken, or timed out
	// next byte: read handed over, write committed, or write lost
	assign byte_step = ((state == S_RD_WAIT) & xfer_done)
		| ((state == S_WR_WAIT) & xfer_done & ~data_ack)
		| (state == S_WR_COMMIT);
	assign byte_last = (byte_idx == sec_len - 1'b1);

	// ==============================
	// head movement
	// ==============================
	always_comb begin
		step_out = cmd.code[6] ? cmd.code[5] : step_dir;
		if (!step_out)
			step_track = head_track + 1'b1;
		else if (head_track == '0)
			step_track = head_track;      // already at the stop
		else
			step_track = head_track - 1'b1;
		seek_track = head_track + (data_reg - track_reg);
	end

	// ==============================
	// register updates, image port, flags
	// ==============================
	always_comb begin
		upd            = '0;
		upd.sector_inc = byte_step & byte_last & multi;
		upd.data_ld    = (state == S_RD_CAPTURE);
		upd.data       = img_rdata;
		upd.data_clr   = in_wait & (cnt_zero | (drq & data_ack));
		if (cmd_go) begin
			case (op)
				CMD_RESTORE: begin
					upd.track_ld = 1'b1;
					upd.track    = '0;
				end
				CMD_SEEK: begin
					upd.track_ld = 1'b1;
					upd.track    = data_reg;
				end
				CMD_STEP_U, CMD_STEP_IN_U, CMD_STEP_OUT_U: begin
					upd.track_ld = 1'b1;
					upd.track    = step_track;
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		img.rd    = (state == S_RD_ISSUE);
		img.wr    = (state == S_WR_COMMIT);
		img.addr  = img_addr;
		img.wdata = data_reg;

		pos.track  = head_track;
		pos.side   = side;
		pos.sector = sector_reg;

		flags.busy        = busy;
		flags.drq         = drq;
		flags.intrq       = intrq;
		flags.head_loaded = head_loaded;
		flags.seek_err    = seek_err;
		flags.wr_fault    = wr_fault;
		flags.lost_data   = lost_data;
		flags.cmd_mode    = cmd_mode;
		flags.track0      = (head_track == '0);
	end

	// ==============================
	// sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= S_IDLE;
			cnt         <= '0;
			head_track  <= '0;
			step_dir    <= 1'b0;
			multi       <= 1'b0;
			is_write    <= 1'b0;
			byte_idx    <= '0;
			busy        <= 1'b0;
			drq         <= 1'b0;
			intrq       <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			wr_fault    <= 1'b0;
			lost_data   <= 1'b0;
			cmd_mode    <= 1'b0;
		end else begin
			if (intrq_ack)
				intrq <= 1'b0;     // status was read
			if (!cnt_zero)
				cnt <= cnt - 1'b1;

			case (state)
				S_IDLE: ;
				S_SETTLE: if (cnt_zero) begin
					busy  <= 1'b0;
					state <= S_END;
				end
				S_SEARCH: begin
					byte_idx <= '0;
					// record not found
					if (!ready || sector_reg == '0 || sector_reg > spt) begin
						seek_err <= 1'b1;
						state    <= S_END;
					end else if (is_write) begin
						cnt   <= CNT_W'(DRQ_DELAY - 1);
						state <= S_WR_WAIT;
					end else begin
						state <= S_RD_ISSUE;
					end
				end
				S_RD_ISSUE: state <= S_RD_CAPTURE;
				S_RD_CAPTURE: begin
					cnt   <= CNT_W'(DRQ_DELAY - 1);
					state <= S_RD_WAIT;
				end
				S_RD_WAIT, S_WR_WAIT: begin
					if (!drq) begin
						if (cnt_zero) begin
							drq <= 1'b1;
							cnt <= CNT_W'(LOST_DATA_TIMEOUT - 1);
						end
					end else if (xfer_done) begin
						drq <= 1'b0;
						if (!data_ack)
							lost_data <= 1'b1;
						if (state == S_WR_WAIT && data_ack)
							state <= S_WR_COMMIT;
					end
				end
				S_WR_COMMIT: ;    // byte goes out on img.wr
				S_END: begin
					busy  <= 1'b0;
					drq   <= 1'b0;
					intrq <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase

			if (byte_step) begin
				cnt <= CNT_W'(DRQ_DELAY - 1);
				if (byte_last)
					state <= multi ? S_SEARCH : S_END;
				else begin
					byte_idx <= byte_idx + 1'b1;
					state    <= is_write ? S_WR_WAIT : S_RD_ISSUE;
				end
			end

			// command decode overrides the running state
			if (cmd_go) begin
				intrq <= 1'b0;
				if (!op[3]) begin   // type I
					busy        <= 1'b1;
					cmd_mode    <= 1'b0;
					head_loaded <= cmd.code[3];
					seek_err    <= 1'b0;
					cnt         <= CNT_W'(SETTLE_CYCLES - 1);
					state       <= S_SETTLE;
				end
				case (op)
					CMD_RESTORE: begin
						head_track <= '0;
						step_dir   <= 1'b1;
					end
					CMD_SEEK: begin
						head_track <= seek_track;
						step_dir   <= (data_reg < track_reg);
					end
					CMD_STEP, CMD_STEP_U, CMD_STEP_IN, CMD_STEP_IN_U,
					CMD_STEP_OUT, CMD_STEP_OUT_U: begin
						step_dir   <= step_out;
						head_track <= step_track;
					end
					CMD_READ, CMD_READ_M, CMD_WRITE, CMD_WRITE_M: begin
						busy      <= 1'b1;
						drq       <= 1'b0;
						cmd_mode  <= 1'b1;
						multi     <= op[0];
						is_write  <= op[1];
						seek_err  <= 1'b0;
						wr_fault  <= 1'b0;
						lost_data <= 1'b0;
						state     <= S_SEARCH;
						if (op[1] && (wp || !ready)) begin
							wr_fault <= 1'b1;
							state    <= S_END;
						end
					end
					CMD_FORCE_INT: begin
						cmd_mode  <= 1'b0;
						drq       <= 1'b0;
						seek_err  <= 1'b0;
						wr_fault  <= 1'b0;
						lost_data <= 1'b0;
						if (state != S_IDLE)
							state <= S_END;
					end
					default: ;        // unsupported codes are ignored
				endcase
			end
		end
	end

endmodule

/* design/fdc_top.sv */
`timescale 1ns/1ps

module fdc_top #(
	parameter int SETTLE_CYCLES     = 4000,
	parameter int DRQ_DELAY         = 15,
	parameter int LOST_DATA_TIMEOUT = 4096
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  fdc_bus_pkg::host_bus_t   host,
	output fdc_bus_pkg::byte_t       dout,
	output logic                     drq,
	output logic                     intrq,
	output logic                     busy,
	input  logic                     wp,
	input  logic                     ready,
	input  logic                     side,
	input  logic                     layout,
	input  fdc_disk_pkg::size_code_t size_code,
	input  fdc_disk_pkg::img_addr_t  disk_size,
	output fdc_disk_pkg::img_req_t   img,
	input  fdc_bus_pkg::byte_t       img_rdata
);
	import fdc_bus_pkg::*;
	import fdc_disk_pkg::*;

	cmd_t       cmd;
	logic       data_ack;
	logic       intrq_ack;
	track_t     track_reg;
	sector_t    sector_reg;
	byte_t      data_reg;
	fdc_flags_t flags;
	reg_upd_t   upd;
	disk_pos_t  pos;
	sec_len_t   byte_idx;
	sector_t    spt;
	sec_len_t   sec_len;
	img_addr_t  img_addr;

	assign drq   = flags.drq;
	assign intrq = flags.intrq;
	assign busy  = flags.busy;

	// ==============================
	// blocks
	// ==============================
	fdc_regs u_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host       (host),
		.dout       (dout),
		.flags      (flags),
		.upd        (upd),
		.ready      (ready),
		.wp         (wp),
		.cmd        (cmd),
		.data_ack   (data_ack),
		.intrq_ack  (intrq_ack),
		.track_reg  (track_reg),
		.sector_reg (sector_reg),
		.data_reg   (data_reg)
	);

	fdc_seq #(
		.SETTLE_CYCLES     (SETTLE_CYCLES),
		.DRQ_DELAY         (DRQ_DELAY),
		.LOST_DATA_TIMEOUT (LOST_DATA_TIMEOUT)
	) u_seq (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cmd        (cmd),
		.data_ack   (data_ack),
		.intrq_ack  (intrq_ack),
		.track_reg  (track_reg),
		.sector_reg (sector_reg),
		.data_reg   (data_reg),
		.ready      (ready),
		.wp         (wp),
		.side       (side),
		.spt        (spt),
		.sec_len    (sec_len),
		.img_addr   (img_addr),
		.pos        (pos),
		.byte_idx   (byte_idx),
		.upd        (upd),
		.flags      (flags),
		.img        (img),
		.img_rdata  (img_rdata)
	);

	fdc_geometry u_geometry (
		.size_code (size_code),
		.layout    (layout),
		.disk_size (disk_size),
		.pos       (pos),
		.byte_idx  (byte_idx),
		.spt       (spt),
		.sec_len   (sec_len),
		.img_addr  (img_addr)
	);

endmodule

/* dv/fdc_image_model.sv */
`timescale 1ns/1ps

module fdc_image_model (
	input  logic                   clk_sys,
	input  fdc_disk_pkg::img_req_t img,
	output fdc_bus_pkg::byte_t     img_rdata
);
	import fdc_bus_pkg::*;
	import fdc_disk_pkg::*;

	localparam int DEPTH = 1 << 20;   // full 20-bit image space

	byte_t mem [0:DEPTH-1];

	// background pattern, every address bit counts
	function automatic byte_t fill_byte(input img_addr_t a);
		return a[7:0] ^ a[15:8] ^ {a[19:16], ~a[19:16]};
	endfunction

	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = fill_byte(img_addr_t'(a));
	end

	// one cycle read latency
	always @(posedge clk_sys) begin
		if (img.rd)
			img_rdata <= mem[img.addr];
		if (img.wr)
			mem[img.addr] <= img.wdata;
	end

	// ==============================
	// backdoor
	// ==============================
	function automatic byte_t peek(input img_addr_t a);
		return mem[a];
	endfunction

	task automatic poke(input img_addr_t a, input byte_t d);
		mem[a] = d;
	endtask

endmodule

/* dv/fdc_tb.sv */
`timescale 1ns/1ps

module fdc_tb;
	import fdc_bus_pkg::*;
	import fdc_disk_pkg::*;

	localparam int SETTLE     = 40;
	localparam int DRQ_DLY    = 4;
	localparam int LOST_TO    = 200;
	localparam int WAIT_LIMIT = SETTLE + LOST_TO + 50;   // longest gap between two events
	// about 60k cycles expected with the sector reads dominating
	localparam int TIMEOUT_CYCLES = 200000;

	logic       clk_sys = 1'b0;
	logic       reset;
	host_bus_t  host;
	byte_t      dout;
	logic       drq;
	logic       intrq;
	logic       busy;
	logic       wp;
	logic       ready;
	logic       side;
	logic       layout;
	size_code_t size_code;
	img_addr_t  disk_size;
	img_req_t   img;
	byte_t      img_rdata;

	logic [15:0] lfsr_state = 16'd31080;
	track_t      cur_track;          // where the head should be
	byte_t       exp_data [0:2047];
	img_addr_t   rd_addr_q [$];
	img_addr_t   wr_addr_q [$];
	byte_t       wr_data_q [$];
	int          cycle_count = 0;

	always #20 clk_sys = ~clk_sys;

	fdc_top #(
		.SETTLE_CYCLES     (SETTLE),
		.DRQ_DELAY         (DRQ_DLY),
		.LOST_DATA_TIMEOUT (LOST_TO)
	) DUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host      (host),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.wp        (wp),
		.ready     (ready),
		.side      (side),
		.layout    (layout),
		.size_code (size_code),
		.disk_size (disk_size),
		.img       (img),
		.img_rdata (img_rdata)
	);

	fdc_image_model u_image (
		.clk_sys   (clk_sys),
		.img       (img),
		.img_rdata (img_rdata)
	);

	// image port monitor
	always @(posedge clk_sys) begin
		if (!reset && img.rd)
			rd_addr_q.push_back(img.addr);
		if (!reset && img.wr) begin
			wr_addr_q.push_back(img.addr);
			wr_data_q.push_back(img.wdata);
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			abort_run("timeout: the tests did not finish within the cycle limit");
	end

	// ==============================
	// reporting and checks
	// ==============================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_addr(input string what, input img_addr_t got, input img_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_len(input string what, input sec_len_t got, input sec_len_t exp);
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	// ==============================
	// reference model of the disk
	// ==============================
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic byte_t rand_byte();
		byte_t v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	function automatic sector_t sectors_per_track(input size_code_t code);
		case (code)
			3'd1:    return 8'd16;
			3'd2:    return 8'd9;
			3'd3:    return 8'd5;
			3'd4:    return 8'd10;
			default: return 8'd26;
		endcase
	endfunction

	function automatic sec_len_t sector_bytes(input size_code_t code);
		case (code)
			3'd1:    return 11'd256;
			3'd2:    return 11'd512;
			3'd3:    return 11'd1024;
			3'd4:    return 11'd512;
			default: return 11'd128;
		endcase
	endfunction

	function automatic img_addr_t image_addr_of(input int sec, input int idx);
		int unsigned trk_idx;
		int unsigned base;
		if (layout) begin
			trk_idx = cur_track;
			base    = side ? disk_size / 2 : 0;   // second side in the upper half
		end else begin
			trk_idx = cur_track * 2 + side;
			base    = 0;
		end
		return img_addr_t'(base + (trk_idx * sectors_per_track(size_code) + sec - 1)
			* sector_bytes(size_code) + idx);
	endfunction

	function automatic byte_t status_type1(input logic trk0);
		byte_t s;
		s                = '0;
		s[ST_TRACK0]     = trk0;
		s[ST_SEEK_ERR]   = ~ready;
		s[ST_WPROT]      = wp;
		s[ST_NOT_READY]  = ~ready;
		return s;
	endfunction

	function automatic byte_t status_type2(input logic rnf, input logic wf);
		byte_t s;
		s                = '0;
		s[ST_SEEK_ERR]   = rnf | ~ready;
		s[ST_WR_FAULT]   = wf;
		s[ST_WPROT]      = wp;
		s[ST_NOT_READY]  = ~ready;
		return s;
	endfunction

	// ==============================
	// host side
	// ==============================
	task automatic host_write(input reg_addr_t a, input byte_t d);
		@(posedge clk_sys);
		#2;
		host.addr  = a;
		host.wdata = d;
		host.wr    = 1'b1;
		@(posedge clk_sys);
		#2;
		host.wr = 1'b0;
	endtask

	task automatic host_read(input reg_addr_t a, output byte_t d);
		@(posedge clk_sys);
		#2;
		host.addr = a;
		host.rd   = 1'b1;
		@(posedge clk_sys);
		#2;
		d       = dout;
		host.rd = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	// one extra cycle so a stale intrq is already cleared
	task automatic issue_cmd(input byte_t code);
		host_write(A_COMMAND, code);
		wait_cycles(1);
	endtask

	task automatic wait_intrq(input logic drq_ok);
		for (int n = 0; !intrq; n++) begin
			if (n == WAIT_LIMIT)
				abort_run("intrq did not rise at the end of the command");
			wait_cycles(1);
			if (drq && !drq_ok)
				abort_run("drq was raised by a command that should move no data");
		end
	endtask

	task automatic wait_drq_high();
		for (int n = 0; !drq; n++) begin
			if (n == WAIT_LIMIT)
				abort_run("drq did not rise for the next data byte");
			wait_cycles(1);
			if (intrq)
				abort_run("the command ended while a data byte was still expected");
		end
	endtask

	task automatic wait_drq_low();
		for (int n = 0; drq; n++) begin
			if (n == WAIT_LIMIT)
				abort_run("drq stayed high after the data access");
			wait_cycles(1);
		end
	endtask

	task automatic check_status(input byte_t exp);
		byte_t got;
		host_read(A_STATUS, got);
		check_byte("status", got, exp);
	endtask

	task automatic check_reg(input reg_addr_t a, input byte_t exp, input string what);
		byte_t got;
		host_read(a, got);
		check_byte(what, got, exp);
	endtask

	task automatic set_disk(input size_code_t code, input logic lay, input logic sd);
		@(posedge clk_sys);
		#2;
		size_code = code;
		layout    = lay;
		side      = sd;
	endtask

	task automatic run_type1(input byte_t code);
		issue_cmd(code);
		wait_intrq(1'b0);
	endtask

	task automatic seek_to(input track_t trk);
		host_write(A_DATA, trk);
		run_type1(8'h10);
		cur_track = trk;
		check_status(status_type1(trk == 0));
		check_reg(A_TRACK, trk, "track register after seek");
	endtask

	task automatic preload(input int sec, input int first);
		byte_t v;
		for (int b = 0; b < sector_bytes(size_code); b++) begin
			v = rand_byte();
			exp_data[first + b] = v;
			u_image.poke(image_addr_of(sec, b), v);
		end
	endtask

	task automatic clear_monitors();
		rd_addr_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic read_bytes(input int count);
		byte_t got;
		for (int b = 0; b < count; b++) begin
			wait_drq_high();
			host_read(A_DATA, got);
			check_byte($sformatf("read byte %0d", b), got, exp_data[b]);
			wait_drq_low();
		end
	endtask

	task automatic write_bytes(input int count);
		for (int b = 0; b < count; b++) begin
			wait_drq_high();
			host_write(A_DATA, exp_data[b]);
			wait_drq_low();
		end
	endtask

	task automatic check_read_addrs(input int first_sec, input int count);
		int len;
		len = sector_bytes(size_code);
		check_len("image reads", sec_len_t'(rd_addr_q.size()), sec_len_t'(count));
		for (int i = 0; i < count; i++)
			check_addr($sformatf("read address %0d", i), rd_addr_q[i],
				image_addr_of(first_sec + i / len, i % len));
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic seek_and_restore();
		seek_to(8'd12);
		run_type1(8'h00);
		cur_track = '0;
		check_status(status_type1(1'b1));
		check_reg(A_TRACK, 8'd0, "track register after restore");
	endtask

	task automatic step_with_update();
		seek_to(8'd5);
		run_type1(8'h50);           // step in with update
		cur_track = 8'd6;
		check_status(status_type1(1'b0));
		check_reg(A_TRACK, 8'd6, "track register after step in");
		run_type1(8'h70);           // step out with update
		cur_track = 8'd5;
		check_status(status_type1(1'b0));
		check_reg(A_TRACK, 8'd5, "track register after step out");
		run_type1(8'h40);           // no update so the register keeps 5
		check_status(status_type1(1'b0));
		check_reg(A_TRACK, 8'd5, "track register after plain step in");
		run_type1(8'h60);
		check_status(status_type1(1'b0));
	endtask

	task automatic read_case(input size_code_t code, input logic lay);
		int sec;
		int len;
		set_disk(code, lay, lay ^ code[0]);
		seek_to(track_t'(3 + code));
		sec = sectors_per_track(code) - code;
		len = sector_bytes(code);
		host_write(A_SECTOR, byte_t'(sec));
		preload(sec, 0);
		clear_monitors();
		issue_cmd(8'h80);
		read_bytes(len);
		wait_intrq(1'b1);
		check_status(status_type2(1'b0, 1'b0));
		check_read_addrs(sec, len);
	endtask

	task automatic read_every_geometry();
		for (int code = 0; code < 5; code++) begin
			read_case(size_code_t'(code), 1'b0);
			read_case(size_code_t'(code), 1'b1);
		end
	endtask

	task automatic write_then_multi_read();
		img_addr_t a;
		set_disk(3'd1, 1'b1, 1'b1);
		seek_to(8'd9);
		host_write(A_SECTOR, 8'd4);
		for (int b = 0; b < 256; b++)
			exp_data[b] = rand_byte();
		clear_monitors();
		issue_cmd(8'hA0);
		write_bytes(256);
		wait_intrq(1'b1);
		check_status(status_type2(1'b0, 1'b0));
		check_len("image writes", sec_len_t'(wr_addr_q.size()), 11'd256);
		for (int b = 0; b < 256; b++) begin
			a = image_addr_of(4, b);
			check_addr($sformatf("write address %0d", b), wr_addr_q[b], a);
			check_byte($sformatf("write data %0d", b), wr_data_q[b], exp_data[b]);
			check_byte($sformatf("image byte %0d", b), u_image.peek(a), exp_data[b]);
		end

		// sectors 25 and 26 then 27 is not found
		set_disk(3'd0, 1'b0, 1'b0);
		seek_to(8'd2);
		host_write(A_SECTOR, 8'd25);
		preload(25, 0);
		preload(26, 128);
		clear_monitors();
		issue_cmd(8'h90);
		read_bytes(256);
		wait_intrq(1'b1);
		check_status(status_type2(1'b1, 1'b0));
		check_reg(A_SECTOR, 8'd27, "sector register after multi read");
		check_read_addrs(25, 256);
	endtask

	task automatic record_and_protect_faults();
		set_disk(3'd2, 1'b0, 1'b1);
		seek_to(8'd2);
		host_write(A_SECTOR, 8'd0);
		issue_cmd(8'h80);
		wait_intrq(1'b0);
		check_status(status_type2(1'b1, 1'b0));
		host_write(A_SECTOR, 8'd10);   // spt + 1
		issue_cmd(8'h80);
		wait_intrq(1'b0);
		check_status(status_type2(1'b1, 1'b0));

		@(posedge clk_sys);
		#2;
		wp = 1'b1;
		host_write(A_SECTOR, 8'd3);
		preload(3, 0);
		clear_monitors();
		issue_cmd(8'hA0);
		wait_intrq(1'b0);
		check_status(status_type2(1'b0, 1'b1));
		check_len("image writes on a protected disk", sec_len_t'(wr_addr_q.size()), '0);
		for (int b = 0; b < 512; b++)
			check_byte($sformatf("protected byte %0d", b), u_image.peek(image_addr_of(3, b)),
				exp_data[b]);
		wp = 1'b0;
	endtask

	task automatic force_interrupt_read();
		set_disk(3'd3, 1'b1, 1'b0);
		seek_to(8'd1);
		host_write(A_SECTOR, 8'd2);
		issue_cmd(8'h80);
		wait_drq_high();
		check_flag("busy during read", busy, 1'b1);
		issue_cmd(8'hD0);
		wait_intrq(1'b1);
		check_flag("busy after force interrupt", busy, 1'b0);
		check_flag("drq after force interrupt", drq, 1'b0);
		check_status(status_type1(1'b0));
		wait_cycles(3);
		check_flag("intrq after status read", intrq, 1'b0);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		reset      = 1'b1;
		host       = '0;
		wp         = 1'b0;
		ready      = 1'b1;
		side       = 1'b0;
		layout     = 1'b0;
		size_code  = '0;
		disk_size  = 20'h80000;   // 512k image with two sides
		cur_track  = '0;
		repeat (10) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		seek_and_restore();
		step_with_update();
		read_every_geometry();
		write_then_multi_read();
		record_and_protect_faults();
		force_interrupt_read();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* files.f */
design/fdc_bus_pkg.sv
design/fdc_disk_pkg.sv
design/fdc_geometry.sv
design/fdc_regs.sv
design/fdc_seq.sv
design/fdc_top.sv
dv/fdc_image_model.sv
dv/fdc_tb.sv
